//--- filelist.f
+incdir+logic
logic/matmul_pkg.sv
logic/matmul_sequencer.sv
logic/mac_accumulate.sv
logic/result_writer.sv
logic/matmul_top.sv
tests/matmul_props.sv
tests/matmul_tb.sv

//--- logic/mac_accumulate.sv
/* mac_accumulate: tag alignment with the read data and the integer
   multiply-accumulate, one sum per dot product */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module mac_accumulate (
	input  logic                clk,
	input  logic                reset_n,
	input  matmul_pkg::mm_data_t a_rd_data,
	input  matmul_pkg::mm_data_t b_rd_data,
	input  logic                elem_valid,
	input  logic                elem_first,
	input  logic                elem_last,
	input  logic                job_last,
	output logic                sum_valid,
	output matmul_pkg::mm_data_t sum,
	output logic                sum_final
);

	import matmul_pkg::*;

	// tags one cycle late, lined up with the memory data
	logic d_valid, d_first, d_last, d_job_last;

	mm_data_t prod;
	mm_data_t acc;
	mm_data_t acc_nxt;

	assign prod    = a_rd_data * b_rd_data;     // low 32 bits kept
	assign acc_nxt = (d_first ? '0 : acc) + prod; // wraps

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			d_valid    <= 1'b0;
			d_first    <= 1'b0;
			d_last     <= 1'b0;
			d_job_last <= 1'b0;
			sum_valid  <= 1'b0;
			sum_final  <= 1'b0;
		end else begin
			d_valid    <= elem_valid;
			d_first    <= elem_first;
			d_last     <= elem_last;
			d_job_last <= job_last;
			sum_valid  <= d_valid && d_last;
			sum_final  <= d_valid && d_last && d_job_last;
		end
	end

	// --------------------------------------------------
	// accumulator and result register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (d_valid) begin
			acc <= acc_nxt;
			if (d_last)
				sum <= acc_nxt; // next dot product may start right away
		end
	end

endmodule

`default_nettype wire

//--- logic/matmul_defs.svh
/* matrix multiply widths and limits
   address, data word, header field and largest dimension */

`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// --------------------------------------------------
// memory ports
// --------------------------------------------------

// word address for the A, B and C memories
`define MM_ADDR_W 16

// one memory word, also one matrix element
`define MM_DATA_W 32

// --------------------------------------------------
// headers and dimensions
// --------------------------------------------------

`define MM_DIM_W 16 // one field of a header word

// M, N and K must each lie in 1 .. MM_MAX_DIM
`define MM_MAX_DIM 8

`endif

//--- logic/matmul_pkg.sv
/* shared types of the matrix multiplier
   address, element, dimension and sequencer state */

`default_nettype none

`include "matmul_defs.svh"

package matmul_pkg;

	// --------------------------------------------------
	// datapath types
	// --------------------------------------------------
	typedef logic [`MM_ADDR_W-1:0] mm_addr_t; // memory word address
	typedef logic [`MM_DATA_W-1:0] mm_data_t; // element, wraps at 32 bits
	typedef logic [`MM_DIM_W-1:0]  mm_dim_t;  // M, N or K, or a loop index

	// --------------------------------------------------
	// sequencer FSM
	// --------------------------------------------------
	typedef enum logic [1:0] {
		IDLE   = 2'd0, // ready for a job
		HEADER = 2'd1, // reading word 0 of A and B
		ISSUE  = 2'd2, // one element per cycle
		DRAIN  = 2'd3  // waiting for the last write
	} seq_state_t;

endpackage

`default_nettype wire

//--- logic/matmul_sequencer.sv
/* matmul_sequencer: start handshake, header capture, i/j/k loop counters,
   operand read addresses and per-element tags */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_sequencer (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                dut_valid,
	output logic                dut_ready,
	output matmul_pkg::mm_addr_t a_rd_addr,
	input  matmul_pkg::mm_data_t a_rd_data,
	output matmul_pkg::mm_addr_t b_rd_addr,
	input  matmul_pkg::mm_data_t b_rd_data,
	output logic                elem_valid,
	output logic                elem_first,
	output logic                elem_last,
	output logic                job_last,
	input  logic                job_done
);

	import matmul_pkg::*;

	seq_state_t state;
	logic       hdr_wait; // first HEADER cycle, data not back yet

	mm_dim_t m_dim, k_dim, n_dim;
	mm_dim_t hdr_m, hdr_k, hdr_n;

	// indices of the element currently on the read ports
	mm_dim_t  i_cnt, j_cnt, k_cnt;
	mm_addr_t a_row_base; // 1 + i*K
	mm_addr_t b_col_base; // 1 + j*K

	// next element
	mm_dim_t  i_nxt, j_nxt, k_nxt;
	mm_addr_t a_nxt, b_nxt;
	mm_addr_t a_row_nxt, b_col_nxt;
	logic     last_k, last_j;
	logic     first_nxt, last_nxt, job_last_nxt;

	assign dut_ready = (state == IDLE);

	// header fields, A gives M and K, B gives N
	assign hdr_m = a_rd_data[`MM_DATA_W-1 -: `MM_DIM_W];
	assign hdr_k = a_rd_data[`MM_DIM_W-1:0];
	assign hdr_n = b_rd_data[`MM_DIM_W-1:0];

	// --------------------------------------------------
	// loop advance
	// --------------------------------------------------
	assign last_k = (k_cnt == k_dim - `MM_DIM_W'(1));
	assign last_j = (j_cnt == n_dim - `MM_DIM_W'(1));

	always_comb begin
		// default: step along k, both operands contiguous
		k_nxt     = k_cnt + `MM_DIM_W'(1);
		j_nxt     = j_cnt;
		i_nxt     = i_cnt;
		a_nxt     = a_rd_addr + `MM_ADDR_W'(1);
		b_nxt     = b_rd_addr + `MM_ADDR_W'(1);
		a_row_nxt = a_row_base;
		b_col_nxt = b_col_base;
		if (last_k) begin
			k_nxt = '0;
			if (last_j) begin
				// next row of C, B restarts at column 0
				j_nxt     = '0;
				i_nxt     = i_cnt + `MM_DIM_W'(1);
				a_row_nxt = a_row_base + mm_addr_t'(k_dim);
				a_nxt     = a_row_nxt;
				b_col_nxt = `MM_ADDR_W'(1);
				b_nxt     = `MM_ADDR_W'(1);
			end else begin
				// same row of A again, next column of B
				j_nxt     = j_cnt + `MM_DIM_W'(1);
				a_nxt     = a_row_base;
				b_col_nxt = b_col_base + mm_addr_t'(k_dim);
				b_nxt     = b_col_nxt;
			end
		end
	end

	assign first_nxt    = (k_nxt == '0);
	assign last_nxt     = (k_nxt == k_dim - `MM_DIM_W'(1));
	assign job_last_nxt = last_nxt && (j_nxt == n_dim - `MM_DIM_W'(1)) &&
		(i_nxt == m_dim - `MM_DIM_W'(1));

	// dimensions only change at header capture
	always_ff @(posedge clk) begin
		if (state == HEADER && !hdr_wait) begin
			m_dim <= hdr_m;
			k_dim <= hdr_k;
			n_dim <= hdr_n; // K field of B is not checked
		end
	end

	// --------------------------------------------------
	// FSM, counters and registered read ports
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state      <= IDLE;
			hdr_wait   <= 1'b0;
			i_cnt      <= '0;
			j_cnt      <= '0;
			k_cnt      <= '0;
			a_row_base <= '0;
			b_col_base <= '0;
			a_rd_addr  <= '0;
			b_rd_addr  <= '0;
			elem_valid <= 1'b0;
			elem_first <= 1'b0;
			elem_last  <= 1'b0;
			job_last   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (dut_valid) begin
						state     <= HEADER;
						hdr_wait  <= 1'b1;
						a_rd_addr <= '0; // header words
						b_rd_addr <= '0;
					end
				end
				HEADER: begin
					if (hdr_wait) begin
						hdr_wait <= 1'b0;
					end else begin
						// element 0 sits at address 1 in both memories
						state      <= ISSUE;
						i_cnt      <= '0;
						j_cnt      <= '0;
						k_cnt      <= '0;
						a_row_base <= `MM_ADDR_W'(1);
						b_col_base <= `MM_ADDR_W'(1);
						a_rd_addr  <= `MM_ADDR_W'(1);
						b_rd_addr  <= `MM_ADDR_W'(1);
						elem_valid <= 1'b1;
						elem_first <= 1'b1;
						elem_last  <= (hdr_k == `MM_DIM_W'(1));
						job_last   <= (hdr_m == `MM_DIM_W'(1)) &&
							(hdr_k == `MM_DIM_W'(1)) && (hdr_n == `MM_DIM_W'(1));
					end
				end
				ISSUE: begin
					if (job_last) begin // last element already out
						state      <= DRAIN;
						elem_valid <= 1'b0;
						elem_first <= 1'b0;
						elem_last  <= 1'b0;
						job_last   <= 1'b0;
					end else begin
						i_cnt      <= i_nxt;
						j_cnt      <= j_nxt;
						k_cnt      <= k_nxt;
						a_row_base <= a_row_nxt;
						b_col_base <= b_col_nxt;
						a_rd_addr  <= a_nxt;
						b_rd_addr  <= b_nxt;
						elem_first <= first_nxt;
						elem_last  <= last_nxt;
						job_last   <= job_last_nxt;
					end
				end
				DRAIN: begin
					if (job_done)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/matmul_top.sv
/* matmul_top: integer matrix multiplier, C = A x B
   sequencer, multiply-accumulate and C writer on the memory ports */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_top (
	input  logic                clk,
	input  logic                reset_n,

	// start handshake
	input  logic                dut_valid,
	output logic                dut_ready,

	// A and B read ports, one cycle read latency
	output matmul_pkg::mm_addr_t a_rd_addr,
	input  matmul_pkg::mm_data_t a_rd_data,
	output matmul_pkg::mm_addr_t b_rd_addr,
	input  matmul_pkg::mm_data_t b_rd_data,

	// C write port
	output logic                c_wr_en,
	output matmul_pkg::mm_addr_t c_wr_addr,
	output matmul_pkg::mm_data_t c_wr_data
);

	import matmul_pkg::*;

	// --------------------------------------------------
	// stage to stage
	// --------------------------------------------------
	logic     elem_valid;
	logic     elem_first;
	logic     elem_last;
	logic     job_last;
	logic     sum_valid;
	mm_data_t sum;
	logic     sum_final;
	logic     job_done;

	matmul_sequencer u_sequencer (
		.clk        (clk),
		.reset_n    (reset_n),
		.dut_valid  (dut_valid),
		.dut_ready  (dut_ready),
		.a_rd_addr  (a_rd_addr),
		.a_rd_data  (a_rd_data),
		.b_rd_addr  (b_rd_addr),
		.b_rd_data  (b_rd_data),
		.elem_valid (elem_valid),
		.elem_first (elem_first),
		.elem_last  (elem_last),
		.job_last   (job_last),
		.job_done   (job_done)
	);

	mac_accumulate u_mac (
		.clk        (clk),
		.reset_n    (reset_n),
		.a_rd_data  (a_rd_data),
		.b_rd_data  (b_rd_data),
		.elem_valid (elem_valid),
		.elem_first (elem_first),
		.elem_last  (elem_last),
		.job_last   (job_last),
		.sum_valid  (sum_valid),
		.sum        (sum),
		.sum_final  (sum_final)
	);

	result_writer u_writer (
		.clk        (clk),
		.reset_n    (reset_n),
		.sum_valid  (sum_valid),
		.sum        (sum),
		.sum_final  (sum_final),
		.c_wr_en    (c_wr_en),
		.c_wr_addr  (c_wr_addr),
		.c_wr_data  (c_wr_data),
		.job_done   (job_done)
	);

endmodule

`default_nettype wire

//--- logic/result_writer.sv
/* result_writer: C memory write port, row-major write address
   and the end-of-job pulse */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module result_writer (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                sum_valid,
	input  matmul_pkg::mm_data_t sum,
	input  logic                sum_final,
	output logic                c_wr_en,
	output matmul_pkg::mm_addr_t c_wr_addr,
	output matmul_pkg::mm_data_t c_wr_data,
	output logic                job_done
);

	import matmul_pkg::*;

	mm_addr_t wr_ptr; // address of the next C word

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			c_wr_en   <= 1'b0;
			c_wr_addr <= '0;
			wr_ptr    <= '0;
			job_done  <= 1'b0;
		end else begin
			c_wr_en  <= sum_valid;
			job_done <= sum_valid && sum_final; // same cycle as last write
			if (sum_valid) begin
				c_wr_addr <= wr_ptr;
				// C restarts at word 0 for the next job
				if (sum_final)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + `MM_ADDR_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sum_valid)
			c_wr_data <= sum;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the matrix multiplier testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module matmul_tb \
	-f filelist.f

# a failing run is reported by the missing pass line
sim_out=$(./obj_dir/Vmatmul_tb 2>&1) || true
echo "$sim_out"

if grep -q "TEST PASS" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- tests/matmul_props.sv
/* protocol assertions for matmul_top, bound into the top level */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_props (
	input logic                 clk,
	input logic                 reset_n,
	input logic                 dut_valid,
	input logic                 dut_ready,
	input matmul_pkg::mm_addr_t a_rd_addr,
	input matmul_pkg::mm_addr_t b_rd_addr,
	input logic                 c_wr_en,
	input matmul_pkg::mm_addr_t c_wr_addr
);

	import matmul_pkg::*;

	localparam int ADDR_LIMIT = 1 + `MM_MAX_DIM * `MM_MAX_DIM;

	mm_addr_t last_wr_addr;
	logic     wrote; // a write already seen in this job

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			last_wr_addr <= '0;
			wrote        <= 1'b0;
		end else if (dut_ready) begin
			wrote <= 1'b0;
		end else if (c_wr_en) begin
			wrote        <= 1'b1;
			last_wr_addr <= c_wr_addr;
		end
	end

	// --------------------------------------------------
	// handshake and address checks
	// --------------------------------------------------
	no_write_idle: assert property (@(posedge clk) disable iff (!reset_n)
		!(c_wr_en && dut_ready))
		else $error("C write while dut_ready is high");

	ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
		dut_valid && dut_ready |=> !dut_ready)
		else $error("dut_ready still high after a job was accepted");

	rd_addr_bound: assert property (@(posedge clk) disable iff (!reset_n)
		(int'(a_rd_addr) < ADDR_LIMIT) && (int'(b_rd_addr) < ADDR_LIMIT))
		else $error("operand read address beyond the largest matrix");

	wr_addr_first: assert property (@(posedge clk) disable iff (!reset_n)
		c_wr_en && !wrote |-> c_wr_addr == '0)
		else $error("first C write of a job not at address 0");

	wr_addr_step: assert property (@(posedge clk) disable iff (!reset_n)
		c_wr_en && wrote |-> c_wr_addr == last_wr_addr + `MM_ADDR_W'(1))
		else $error("C write address did not advance by one");

endmodule

bind matmul_top matmul_props u_props (
	.clk       (clk),
	.reset_n   (reset_n),
	.dut_valid (dut_valid),
	.dut_ready (dut_ready),
	.a_rd_addr (a_rd_addr),
	.b_rd_addr (b_rd_addr),
	.c_wr_en   (c_wr_en),
	.c_wr_addr (c_wr_addr)
);

`default_nettype wire

//--- tests/matmul_tb.sv
/* testbench for matmul_top: clock, reset, A/B/C memory models, jobs,
   golden model, write checks and watchdog */

`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_tb;

	import matmul_pkg::*;

	localparam int NUM_JOBS = 12;
	localparam int MAX_DIM  = `MM_MAX_DIM;
	localparam int MEM_USED = 1 + MAX_DIM * MAX_DIM; // header plus largest matrix
	localparam int WDOG_CYC = NUM_JOBS * (MAX_DIM * MAX_DIM * MAX_DIM + 40);

	logic     clk;
	logic     reset_n;
	logic     dut_valid;
	logic     dut_ready;
	mm_addr_t a_rd_addr, b_rd_addr;
	mm_data_t a_rd_data, b_rd_data;
	logic     c_wr_en;
	mm_addr_t c_wr_addr;
	mm_data_t c_wr_data;

	mm_data_t a_mem [0:65535];
	mm_data_t b_mem [0:65535];
	mm_data_t c_mem [0:65535];
	mm_data_t exp_c [0:65535]; // golden C, row-major
	mm_addr_t a_addr_q, b_addr_q;

	string test_name;
	int    cur_m, cur_n, cur_k;
	int    jobs_started = 0;
	int    jobs_done    = 0;
	int    wr_count     = 0;
	int    job_cycles   = 0;
	logic  ready_q      = 1'b1;

	matmul_top DUT (
		.clk       (clk),
		.reset_n   (reset_n),
		.dut_valid (dut_valid),
		.dut_ready (dut_ready),
		.a_rd_addr (a_rd_addr),
		.a_rd_data (a_rd_data),
		.b_rd_addr (b_rd_addr),
		.b_rd_data (b_rd_data),
		.c_wr_en   (c_wr_en),
		.c_wr_addr (c_wr_addr),
		.c_wr_data (c_wr_data)
	);

	always #5 clk = ~clk;

	// read data shows up one cycle after its address
	always @(negedge clk) begin
		a_addr_q  <= a_rd_addr;
		b_addr_q  <= b_rd_addr;
		a_rd_data <= a_mem[a_addr_q];
		b_rd_data <= b_mem[b_addr_q];
	end

	task automatic report_mismatch(input string what, input mm_data_t exp, input mm_data_t act);
		$display("ERROR %s: %s expected %0d (0x%08h) actual %0d (0x%08h)",
			test_name, what, $signed(exp), exp, $signed(act), act);
		$display("TEST FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic report_problem(input string what);
		$display("ERROR %s: %s", test_name, what);
		$display("TEST FAIL");
		$fatal(1, "protocol check failed");
	endtask

	// --------------------------------------------------
	// write monitor and job timing
	// --------------------------------------------------
	always @(negedge clk) begin
		if (reset_n) begin
			if (c_wr_en) begin
				assert (!dut_ready) else report_problem("C memory written while the DUT was idle");
				assert (c_wr_addr == mm_addr_t'(wr_count))
				else report_mismatch("write address", mm_data_t'(wr_count), mm_data_t'(c_wr_addr));
				assert (c_wr_data == exp_c[c_wr_addr])
				else report_mismatch("C word", exp_c[c_wr_addr], c_wr_data);
				c_mem[c_wr_addr] = c_wr_data;
				wr_count++;
			end
			if (ready_q && !dut_ready) begin // accepted on the last rising edge
				jobs_started++;
				wr_count   = 0;
				job_cycles = 0;
			end else if (!ready_q) begin
				job_cycles++;
			end
			if (!ready_q && dut_ready) begin
				assert (wr_count == cur_m * cur_n)
				else report_mismatch("write count", mm_data_t'(cur_m * cur_n), mm_data_t'(wr_count));
				assert (job_cycles == cur_m * cur_n * cur_k + 5)
				else report_mismatch("cycles to ready", mm_data_t'(cur_m * cur_n * cur_k + 5),
					mm_data_t'(job_cycles));
				jobs_done++;
			end
			ready_q = dut_ready;
		end
	end

	// --------------------------------------------------
	// job setup and golden model
	// --------------------------------------------------
	task automatic load_job(input int m, input int n, input int k);
		for (int x = 0; x < MEM_USED; x++) begin
			a_mem[mm_addr_t'(x)] = {mm_addr_t'(x) ^ 16'hA5A5, ~mm_addr_t'(x)};
			b_mem[mm_addr_t'(x)] = {~mm_addr_t'(x), mm_addr_t'(x) ^ 16'h3C3C};
		end
		a_mem[0] = {mm_dim_t'(m), mm_dim_t'(k)}; // M | K
		b_mem[0] = {mm_dim_t'(k), mm_dim_t'(n)}; // K | N
		cur_m = m;
		cur_n = n;
		cur_k = k;
	endtask

	task automatic set_a(input int i, input int kk, input mm_data_t v);
		a_mem[mm_addr_t'(1 + i * cur_k + kk)] = v; // row-major
	endtask

	task automatic set_b(input int kk, input int j, input mm_data_t v);
		b_mem[mm_addr_t'(1 + j * cur_k + kk)] = v; // column-major
	endtask

	task automatic compute_expected();
		mm_data_t acc;
		for (int i = 0; i < cur_m; i++) begin
			for (int j = 0; j < cur_n; j++) begin
				acc = '0;
				for (int kk = 0; kk < cur_k; kk++)
					acc = acc + a_mem[mm_addr_t'(1 + i * cur_k + kk)] *
						b_mem[mm_addr_t'(1 + j * cur_k + kk)]; // low 32 bits
				exp_c[mm_addr_t'(i * cur_n + j)] = acc;
				c_mem[mm_addr_t'(i * cur_n + j)] = ~acc; // stale marker
			end
		end
	endtask

	function automatic mm_data_t rand_elem();
		int sel;
		sel = $urandom_range(0, 7);
		case (sel)
			0: return 32'h7FFF_FFFF;
			1: return 32'h8000_0000;
			2: return 32'hFFFF_FFFF;
			default: return $urandom;
		endcase
	endfunction

	task automatic fill_random();
		for (int i = 0; i < cur_m; i++)
			for (int kk = 0; kk < cur_k; kk++)
				set_a(i, kk, rand_elem());
		for (int kk = 0; kk < cur_k; kk++)
			for (int j = 0; j < cur_n; j++)
				set_b(kk, j, rand_elem());
	endtask

	// entered on a falling edge, returns on a falling edge with the DUT idle
	task automatic run_job(input string name, input logic poke_busy);
		int target;
		target    = jobs_done + 1;
		test_name = name;
		compute_expected();
		dut_valid = 1'b1;
		@(negedge clk);
		dut_valid = 1'b0;
		if (poke_busy) begin
			repeat (2) @(negedge clk);
			dut_valid = 1'b1; // job still busy, must be ignored
			@(negedge clk);
			dut_valid = 1'b0;
		end
		wait (jobs_done == target);
		if (poke_busy)
			repeat (2) @(negedge clk); // a stored start would begin a job here
		assert (jobs_started == target)
		else report_mismatch("job count", mm_data_t'(target), mm_data_t'(jobs_started));
		for (int x = 0; x < cur_m * cur_n; x++)
			assert (c_mem[mm_addr_t'(x)] == exp_c[mm_addr_t'(x)])
			else report_mismatch("C readback", exp_c[mm_addr_t'(x)], c_mem[mm_addr_t'(x)]);
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		clk       = 1'b0;
		reset_n   = 1'b0;
		dut_valid = 1'b0;
		a_rd_data <= '0;
		b_rd_data <= '0;
		a_addr_q  <= '0;
		b_addr_q  <= '0;
		test_name = "reset";
		void'($urandom(46672));
		repeat (16) @(negedge clk);
		reset_n = 1'b1;
		repeat (4) @(negedge clk);
		assert (dut_ready === 1'b1) else report_problem("dut_ready is not high after reset");

		load_job(2, 2, 3); // 2x3 times 3x2
		for (int i = 0; i < 2; i++)
			for (int kk = 0; kk < 3; kk++)
				set_a(i, kk, mm_data_t'(i * 3 + kk + 1));
		for (int kk = 0; kk < 3; kk++)
			for (int j = 0; j < 2; j++)
				set_b(kk, j, mm_data_t'(7 + kk * 2 + j));
		run_job("fixed_2x3x2", 1'b0);

		load_job(1, 1, 1);
		set_a(0, 0, 32'hFFFF_FFF9); // -7
		set_b(0, 0, 32'd123456789);
		run_job("single_1x1x1", 1'b0);

		for (int t = 0; t < 9; t++) begin
			load_job($urandom_range(1, MAX_DIM), $urandom_range(1, MAX_DIM),
				$urandom_range(1, MAX_DIM));
			fill_random();
			run_job($sformatf("random_%0d", t), t == 3);
		end

		load_job(MAX_DIM, MAX_DIM, MAX_DIM);
		fill_random();
		run_job("random_max", 1'b1);

		$display("TEST PASS");
		$finish;
	end

	initial begin
		repeat (WDOG_CYC) @(posedge clk);
		$display("ERROR watchdog: the jobs did not finish within %0d cycles", WDOG_CYC);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
